// ==== verilog/iq_pkg.sv ====
// -------------------------------------
// sizes and packed structs shared by the issue queue RTL
// and its testbench, referenced as iq_pkg::name
// -------------------------------------

`default_nettype none

package iq_pkg;

    // ----------------------------------------
    // sizes

    localparam int LOG_PR_COUNT       = 7;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_BANK_COUNT     = 1 << LOG_PRF_BANK_COUNT;
    localparam int UPPER_PR_WIDTH     = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;
    localparam int LOG_ROB_ENTRIES    = 6;

    // ----------------------------------------
    // scalar types

    // low bits pick the bank, upper bits index within it
    typedef logic [LOG_PR_COUNT-1:0]    pr_t;
    typedef logic [UPPER_PR_WIDTH-1:0]  upper_pr_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;

    // ----------------------------------------
    // structs

    typedef struct packed {
        pr_t  pr;
        logic ready;
        logic is_zero;
    } src_t;

    // op as dispatched into the queue
    typedef struct packed {
        logic       is_alu_reg;
        logic       is_mdu;
        logic [3:0] op;
        src_t       a;
        src_t       b;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } iq_op_t;

    // one writeback slot per register file bank
    typedef struct packed {
        logic [PRF_BANK_COUNT-1:0]      valid;
        upper_pr_t [PRF_BANK_COUNT-1:0] upper_pr;
    } wb_bus_t;

    // shared by both pipes, qualified by the per-pipe valids
    typedef struct packed {
        logic [3:0] op;
        logic       a_is_reg;
        logic       a_is_bus_forward;
        pr_t        a_pr;
        logic       b_is_reg;
        logic       b_is_bus_forward;
        pr_t        b_pr;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } issue_t;

    typedef struct packed {
        logic a_valid;
        pr_t  a_pr;
        logic b_valid;
        pr_t  b_pr;
    } prf_req_t;

endpackage

`default_nettype wire

// ==== verilog/oldest_pick.sv ====
// -------------------------------------
// lowest-index priority picker with one-hot grant and the
// mask of every position from the grant upward
// -------------------------------------

`default_nettype none

module oldest_pick #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] grant,
    output logic [WIDTH-1:0] at_or_above
);

    // walk up from index 0, the first request seen wins
    always_comb begin
        logic seen;
        seen = 1'b0;
        grant = '0;
        at_or_above = '0;
        for (int i = 0; i < WIDTH; i++) begin
            grant[i] = req[i] & ~seen;
            seen = seen | req[i];
            at_or_above[i] = seen;
        end
    end

    // ----------------------------------------
    // checks

    // grant must be one-hot or zero and sit at the bottom edge of the mask
    always_comb begin
        assert ($onehot0(grant) && ((at_or_above & ~(at_or_above << 1)) == grant))
        else $error("oldest_pick: grant and mask disagree");
    end

endmodule

`default_nettype wire

// ==== verilog/operand_wakeup.sv ====
// -------------------------------------
// matches every stored source register against the banked
// writeback bus, purely combinational
// -------------------------------------

`default_nettype none

module operand_wakeup #(
    parameter int ENTRIES = 12
) (
    input  iq_pkg::pr_t [ENTRIES-1:0] a_pr,
    input  iq_pkg::pr_t [ENTRIES-1:0] b_pr,
    input  iq_pkg::wb_bus_t           wb_bus,
    output logic [ENTRIES-1:0]        a_fwd,
    output logic [ENTRIES-1:0]        b_fwd
);

    localparam int BANK_W = iq_pkg::LOG_PRF_BANK_COUNT;
    localparam int PR_W   = iq_pkg::LOG_PR_COUNT;

    // a register hits when its bank slot is valid and carries the same
    // upper number
    function automatic logic bus_hit(
        input iq_pkg::pr_t     pr,
        input iq_pkg::wb_bus_t bus
    );
        logic [BANK_W-1:0]  bank;
        iq_pkg::upper_pr_t  upper;
        bank  = pr[BANK_W-1:0];
        upper = pr[PR_W-1:BANK_W];
        return bus.valid[bank] && (bus.upper_pr[bank] == upper);
    endfunction

    // ----------------------------------------
    // per entry compare

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            a_fwd[i] = bus_hit(a_pr[i], wb_bus);
            b_fwd[i] = bus_hit(b_pr[i], wb_bus);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/collapse_queue.sv ====
// -------------------------------------
// oldest-first entry storage, collapses over the issued slot,
// fills the lowest free slot on enqueue and latches wakeups
// -------------------------------------

`default_nettype none

module collapse_queue #(
    parameter int ENTRIES = 12
) (
    input  logic                         CLK,
    input  logic                         nRST,

    // enqueue handshake
    input  logic                         enq_valid,
    input  iq_pkg::iq_op_t               enq_op,
    output logic                         enq_ready,

    // from selection and wakeup
    input  logic [ENTRIES-1:0]           issue_mask,
    input  logic [ENTRIES-1:0]           a_fwd,
    input  logic [ENTRIES-1:0]           b_fwd,

    // stored state
    output iq_pkg::iq_op_t [ENTRIES-1:0] entries,
    output logic [ENTRIES-1:0]           valid
);

    localparam int OP_W = $bits(iq_pkg::iq_op_t);

    iq_pkg::iq_op_t [ENTRIES-1:0] entries_q;
    iq_pkg::iq_op_t [ENTRIES-1:0] entries_d;
    logic [ENTRIES-1:0]           valid_q;
    logic [ENTRIES-1:0]           valid_d;

    // slot contents one position up, zero above the top
    iq_pkg::iq_op_t [ENTRIES-1:0] entries_up;
    logic [ENTRIES-1:0]           valid_up;
    logic [ENTRIES-1:0]           a_fwd_up;
    logic [ENTRIES-1:0]           b_fwd_up;
    logic [ENTRIES-1:0]           enq_up;

    // what each slot looks at after the collapse decision
    iq_pkg::iq_op_t [ENTRIES-1:0] cur_entry;
    logic [ENTRIES-1:0]           cur_valid;
    logic [ENTRIES-1:0]           cur_a_fwd;
    logic [ENTRIES-1:0]           cur_b_fwd;
    logic [ENTRIES-1:0]           cur_enq;

    logic [ENTRIES-1:0]           free_onehot;
    logic [ENTRIES-1:0]           enq_onehot;

    // stored tags without the ready bits, which may still latch a wakeup
    logic [ENTRIES-1:0][iq_pkg::LOG_PR_COUNT+iq_pkg::LOG_ROB_ENTRIES-1:0] held_tag;

    // ----------------------------------------
    // enqueue slot

    oldest_pick #(
        .WIDTH(ENTRIES)
    ) free_pick (
        .req        (~valid_q),
        .grant      (free_onehot),
        .at_or_above()
    );

    assign enq_ready  = |(~valid_q);
    assign enq_onehot = free_onehot & {ENTRIES{enq_valid}};

    // ----------------------------------------
    // collapse mux

    assign entries_up = {{OP_W{1'b0}}, entries_q[ENTRIES-1:1]};
    assign valid_up   = {1'b0, valid_q[ENTRIES-1:1]};
    assign a_fwd_up   = {1'b0, a_fwd[ENTRIES-1:1]};
    assign b_fwd_up   = {1'b0, b_fwd[ENTRIES-1:1]};
    assign enq_up     = {1'b0, enq_onehot[ENTRIES-1:1]};

    // slots at or above the issued one take from above
    assign cur_valid = (issue_mask & valid_up) | (~issue_mask & valid_q);
    assign cur_a_fwd = (issue_mask & a_fwd_up) | (~issue_mask & a_fwd);
    assign cur_b_fwd = (issue_mask & b_fwd_up) | (~issue_mask & b_fwd);
    assign cur_enq   = (issue_mask & enq_up) | (~issue_mask & enq_onehot);

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            cur_entry[i] = issue_mask[i] ? entries_up[i] : entries_q[i];
        end
    end

    // held entries keep their op and latch any wakeup, empty ones take
    // the enqueued op
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            if (cur_valid[i]) begin
                valid_d[i]         = 1'b1;
                entries_d[i]       = cur_entry[i];
                entries_d[i].a.ready = cur_entry[i].a.ready | cur_a_fwd[i];
                entries_d[i].b.ready = cur_entry[i].b.ready | cur_b_fwd[i];
            end else begin
                valid_d[i]   = cur_enq[i];
                entries_d[i] = enq_op;
            end
        end
    end

    // ----------------------------------------
    // state

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge CLK) begin
        entries_q <= entries_d;
    end

    assign entries = entries_q;
    assign valid   = valid_q;

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            held_tag[i] = {entries_q[i].dest_pr, entries_q[i].rob_index};
        end
    end

    // a full queue that issues nothing must keep every stored op
    a_full_hold: assert property (
        @(posedge CLK) disable iff (!nRST)
        (!enq_ready && !(|issue_mask)) |=> ($stable(valid_q) && $stable(held_tag))
    ) else $error("collapse_queue: slot written while full");

endmodule

`default_nettype wire

// ==== verilog/issue_select.sv ====
// -------------------------------------
// readiness check, oldest-ready pick and one-hot mux out to
// the pipes and the register file read requests
// -------------------------------------

`default_nettype none

module issue_select #(
    parameter int ENTRIES = 12
) (
    input  iq_pkg::iq_op_t [ENTRIES-1:0] entries,
    input  logic [ENTRIES-1:0]           valid,
    input  logic [ENTRIES-1:0]           a_fwd,
    input  logic [ENTRIES-1:0]           b_fwd,
    input  logic                         alu_issue_ready,
    input  logic                         mdu_issue_ready,
    output logic                         alu_issue_valid,
    output logic                         mdu_issue_valid,
    output iq_pkg::issue_t               issue,
    output iq_pkg::prf_req_t             prf_req,
    output logic [ENTRIES-1:0]           issue_mask
);

    logic [ENTRIES-1:0] ready_vec;
    logic [ENTRIES-1:0] grant;

    // ----------------------------------------
    // readiness

    // pipe ready hides that pipe's entries, operands need ready,
    // a bus hit this cycle, or the zero register
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            ready_vec[i] = valid[i]
                & ((entries[i].is_alu_reg & alu_issue_ready)
                   | (entries[i].is_mdu & mdu_issue_ready))
                & (entries[i].a.ready | a_fwd[i] | entries[i].a.is_zero)
                & (entries[i].b.ready | b_fwd[i] | entries[i].b.is_zero);
        end
    end

    oldest_pick #(
        .WIDTH(ENTRIES)
    ) issue_pick (
        .req        (ready_vec),
        .grant      (grant),
        .at_or_above(issue_mask)
    );

    // ----------------------------------------
    // one-hot mux

    always_comb begin
        alu_issue_valid = 1'b0;
        mdu_issue_valid = 1'b0;
        issue   = '0;
        prf_req = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (grant[i]) begin
                alu_issue_valid          |= entries[i].is_alu_reg;
                mdu_issue_valid          |= entries[i].is_mdu;
                issue.op                 |= entries[i].op;
                issue.a_is_reg           |= ~(entries[i].a.is_zero | a_fwd[i]);
                issue.a_is_bus_forward   |= a_fwd[i];
                issue.a_pr               |= entries[i].a.pr;
                issue.b_is_reg           |= ~(entries[i].b.is_zero | b_fwd[i]);
                issue.b_is_bus_forward   |= b_fwd[i];
                issue.b_pr               |= entries[i].b.pr;
                issue.dest_pr            |= entries[i].dest_pr;
                issue.rob_index          |= entries[i].rob_index;
                // forwarded or zero operands skip the register file
                prf_req.a_valid |= ~(a_fwd[i] | entries[i].a.is_zero);
                prf_req.a_pr    |= entries[i].a.pr;
                prf_req.b_valid |= ~(b_fwd[i] | entries[i].b.is_zero);
                prf_req.b_pr    |= entries[i].b.pr;
            end
        end
    end

    // an op targets exactly one pipe
    always_comb begin
        assert (!(alu_issue_valid && mdu_issue_valid))
        else $error("issue_select: both pipes issued together");
    end

endmodule

`default_nettype wire

// ==== verilog/alu_mdu_iq.sv ====
// -------------------------------------
// ALU reg-reg and MDU issue queue, wires storage, wakeup
// and selection together
// -------------------------------------

`default_nettype none

module alu_mdu_iq #(
    parameter int ENTRIES = 12
) (
    input  logic                     CLK,
    input  logic                     nRST,

    // enqueue
    input  logic                     enq_valid,
    input  iq_pkg::iq_op_t           enq_op,
    output logic                     enq_ready,

    // writeback by bank
    input  iq_pkg::wb_bus_t          wb_bus,

    // pipes
    input  logic                     alu_issue_ready,
    input  logic                     mdu_issue_ready,
    output logic                     alu_issue_valid,
    output logic                     mdu_issue_valid,
    output iq_pkg::issue_t           issue,
    output iq_pkg::prf_req_t         prf_req
);

    iq_pkg::iq_op_t [ENTRIES-1:0] entries;
    logic [ENTRIES-1:0]           valid;
    iq_pkg::pr_t [ENTRIES-1:0]    a_pr;
    iq_pkg::pr_t [ENTRIES-1:0]    b_pr;
    logic [ENTRIES-1:0]           a_fwd;
    logic [ENTRIES-1:0]           b_fwd;
    logic [ENTRIES-1:0]           issue_mask;

    // source registers for the wakeup compare
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            a_pr[i] = entries[i].a.pr;
            b_pr[i] = entries[i].b.pr;
        end
    end

    collapse_queue #(
        .ENTRIES(ENTRIES)
    ) queue (
        .CLK       (CLK),
        .nRST      (nRST),
        .enq_valid (enq_valid),
        .enq_op    (enq_op),
        .enq_ready (enq_ready),
        .issue_mask(issue_mask),
        .a_fwd     (a_fwd),
        .b_fwd     (b_fwd),
        .entries   (entries),
        .valid     (valid)
    );

    operand_wakeup #(
        .ENTRIES(ENTRIES)
    ) wakeup (
        .a_pr  (a_pr),
        .b_pr  (b_pr),
        .wb_bus(wb_bus),
        .a_fwd (a_fwd),
        .b_fwd (b_fwd)
    );

    issue_select #(
        .ENTRIES(ENTRIES)
    ) select (
        .entries        (entries),
        .valid          (valid),
        .a_fwd          (a_fwd),
        .b_fwd          (b_fwd),
        .alu_issue_ready(alu_issue_ready),
        .mdu_issue_ready(mdu_issue_ready),
        .alu_issue_valid(alu_issue_valid),
        .mdu_issue_valid(mdu_issue_valid),
        .issue          (issue),
        .prf_req        (prf_req),
        .issue_mask     (issue_mask)
    );

endmodule

`default_nettype wire

// ==== dv/iq_tb.sv ====
// ----------------------------------------
// testbench for the issue queue, replays the cases file one
// line per cycle and checks the issue outputs against it
// ----------------------------------------

`default_nettype none

module iq_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    ENTRIES         = 4;
    localparam int    CLK_PERIOD      = 20;
    localparam int    RESET_CYCLES    = 8;
    localparam int    WATCHDOG_MARGIN = 20;
    localparam int    MAX_CASES       = 256;
    localparam int    NUM_FIELDS      = 27;
    localparam string CASES_FILE      = "dv/iq_cases.txt";

    // ----------------------------------------
    // column positions in the cases file

    localparam int F_ENQ      = 0;
    localparam int F_PIPE     = 1;
    localparam int F_OP       = 2;
    localparam int F_A_PR     = 3;
    localparam int F_A_RDY    = 4;
    localparam int F_A_ZERO   = 5;
    localparam int F_B_PR     = 6;
    localparam int F_B_RDY    = 7;
    localparam int F_B_ZERO   = 8;
    localparam int F_DEST     = 9;
    localparam int F_ROB      = 10;
    localparam int F_WB_V     = 11;
    localparam int F_WB_BANK  = 12;
    localparam int F_WB_UPPER = 13;
    localparam int F_ALU_RDY  = 14;
    localparam int F_MDU_RDY  = 15;
    localparam int X_ENQ_RDY  = 16;
    localparam int X_ALU_V    = 17;
    localparam int X_MDU_V    = 18;
    localparam int X_DEST     = 19;
    localparam int X_ROB      = 20;
    localparam int X_A_REG    = 21;
    localparam int X_A_FWD    = 22;
    localparam int X_B_REG    = 23;
    localparam int X_B_FWD    = 24;
    localparam int X_A_REQ    = 25;
    localparam int X_B_REQ    = 26;

    logic             CLK;
    logic             nRST;
    logic             enq_valid;
    iq_pkg::iq_op_t   enq_op;
    logic             enq_ready;
    iq_pkg::wb_bus_t  wb_bus;
    logic             alu_issue_ready;
    logic             mdu_issue_ready;
    logic             alu_issue_valid;
    logic             mdu_issue_valid;
    iq_pkg::issue_t   issue;
    iq_pkg::prf_req_t prf_req;

    int   case_data [MAX_CASES][NUM_FIELDS];
    int   num_cases;
    int   error_count;
    int   check_count;
    logic load_done;

    alu_mdu_iq #(
        .ENTRIES(ENTRIES)
    ) uut (
        .CLK            (CLK),
        .nRST           (nRST),
        .enq_valid      (enq_valid),
        .enq_op         (enq_op),
        .enq_ready      (enq_ready),
        .wb_bus         (wb_bus),
        .alu_issue_ready(alu_issue_ready),
        .mdu_issue_ready(mdu_issue_ready),
        .alu_issue_valid(alu_issue_valid),
        .mdu_issue_valid(mdu_issue_valid),
        .issue          (issue),
        .prf_req        (prf_req)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ----------------------------------------
    // cases file

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        int    f [NUM_FIELDS];
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("could not open the cases file %s", CASES_FILE);
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // blank lines and # comments carry no case
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                    f[18], f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26]);
                if (n != NUM_FIELDS) begin
                    $display("a line of the cases file has %0d columns instead of %0d",
                             n, NUM_FIELDS);
                    error_count++;
                end else if (num_cases >= MAX_CASES) begin
                    $display("the cases file holds more than %0d cases", MAX_CASES);
                    error_count++;
                end else begin
                    for (int j = 0; j < NUM_FIELDS; j++) begin
                        case_data[num_cases][j] = f[j];
                    end
                    num_cases++;
                end
            end
            $fclose(fd);
            if (num_cases == 0) begin
                $display("the cases file holds no cases");
                error_count++;
            end
        end
    endtask

    // ----------------------------------------
    // stimulus

    function automatic iq_pkg::iq_op_t build_op(input int row);
        iq_pkg::iq_op_t op;
        op = '0;
        if (case_data[row][F_ENQ][0]) begin
            op.is_alu_reg = ~case_data[row][F_PIPE][0];
            op.is_mdu     = case_data[row][F_PIPE][0];
            op.op         = case_data[row][F_OP][3:0];
            op.a.pr       = case_data[row][F_A_PR][iq_pkg::LOG_PR_COUNT-1:0];
            op.a.ready    = case_data[row][F_A_RDY][0];
            op.a.is_zero  = case_data[row][F_A_ZERO][0];
            op.b.pr       = case_data[row][F_B_PR][iq_pkg::LOG_PR_COUNT-1:0];
            op.b.ready    = case_data[row][F_B_RDY][0];
            op.b.is_zero  = case_data[row][F_B_ZERO][0];
            op.dest_pr    = case_data[row][F_DEST][iq_pkg::LOG_PR_COUNT-1:0];
            op.rob_index  = case_data[row][F_ROB][iq_pkg::LOG_ROB_ENTRIES-1:0];
        end
        return op;
    endfunction

    // at most one bank writes back per case line
    function automatic iq_pkg::wb_bus_t build_wb(input int row);
        iq_pkg::wb_bus_t                       wb;
        logic [iq_pkg::LOG_PRF_BANK_COUNT-1:0] bank;
        wb   = '0;
        bank = case_data[row][F_WB_BANK][iq_pkg::LOG_PRF_BANK_COUNT-1:0];
        if (case_data[row][F_WB_V][0]) begin
            wb.valid[bank]    = 1'b1;
            wb.upper_pr[bank] = case_data[row][F_WB_UPPER][iq_pkg::UPPER_PR_WIDTH-1:0];
        end
        return wb;
    endfunction

    task automatic drive_case(input int row);
        enq_valid       <= case_data[row][F_ENQ][0];
        enq_op          <= build_op(row);
        wb_bus          <= build_wb(row);
        alu_issue_ready <= case_data[row][F_ALU_RDY][0];
        mdu_issue_ready <= case_data[row][F_MDU_RDY][0];
    endtask

    // ----------------------------------------
    // checks

    task automatic compare_field(input int row, input string name,
                                 input int got, input int expected);
        check_count++;
        assert (got == expected)
        else begin
            $display("FAIL t=%0t case %0d %s got %0h expected %0h",
                     $time, row, name, got, expected);
            error_count++;
        end
    endtask

    // latest earlier line that enqueued the op with this rob index
    function automatic int find_enq_row(input int row, input int rob);
        int found;
        found = -1;
        for (int j = 0; j < row; j++) begin
            if (case_data[j][F_ENQ] != 0 && case_data[j][F_ROB] == rob) begin
                found = j;
            end
        end
        return found;
    endfunction

    // the issued op carries the fields it was enqueued with
    task automatic check_payload(input int row);
        int src;
        if (case_data[row][X_ALU_V] != 0 || case_data[row][X_MDU_V] != 0) begin
            src = find_enq_row(row, case_data[row][X_ROB]);
            check_count++;
            assert (src >= 0)
            else begin
                $display("case %0d expects an issue of rob index %0h that was never enqueued",
                         row, case_data[row][X_ROB]);
                error_count++;
            end
            if (src >= 0) begin
                compare_field(row, "issue.op", int'(issue.op), case_data[src][F_OP]);
                compare_field(row, "issue.a_pr", int'(issue.a_pr), case_data[src][F_A_PR]);
                compare_field(row, "issue.b_pr", int'(issue.b_pr), case_data[src][F_B_PR]);
                if (case_data[row][X_A_REQ] != 0) begin
                    compare_field(row, "prf_req.a_pr", int'(prf_req.a_pr),
                                  case_data[src][F_A_PR]);
                end
                if (case_data[row][X_B_REQ] != 0) begin
                    compare_field(row, "prf_req.b_pr", int'(prf_req.b_pr),
                                  case_data[src][F_B_PR]);
                end
            end
        end
    endtask

    task automatic check_case(input int row);
        compare_field(row, "enq_ready", int'(enq_ready), case_data[row][X_ENQ_RDY]);
        compare_field(row, "alu_issue_valid", int'(alu_issue_valid), case_data[row][X_ALU_V]);
        compare_field(row, "mdu_issue_valid", int'(mdu_issue_valid), case_data[row][X_MDU_V]);
        compare_field(row, "issue.dest_pr", int'(issue.dest_pr), case_data[row][X_DEST]);
        compare_field(row, "issue.rob_index", int'(issue.rob_index), case_data[row][X_ROB]);
        compare_field(row, "issue.a_is_reg", int'(issue.a_is_reg), case_data[row][X_A_REG]);
        compare_field(row, "issue.a_is_bus_forward", int'(issue.a_is_bus_forward),
                      case_data[row][X_A_FWD]);
        compare_field(row, "issue.b_is_reg", int'(issue.b_is_reg), case_data[row][X_B_REG]);
        compare_field(row, "issue.b_is_bus_forward", int'(issue.b_is_bus_forward),
                      case_data[row][X_B_FWD]);
        compare_field(row, "prf_req.a_valid", int'(prf_req.a_valid), case_data[row][X_A_REQ]);
        compare_field(row, "prf_req.b_valid", int'(prf_req.b_valid), case_data[row][X_B_REQ]);
        check_payload(row);
    endtask

    // ----------------------------------------
    // main sequence

    initial begin
        CLK             = 1'b0;
        nRST            = 1'b0;
        enq_valid       = 1'b0;
        enq_op          = '0;
        wb_bus          = '0;
        alu_issue_ready = 1'b0;
        mdu_issue_ready = 1'b0;
        num_cases       = 0;
        error_count     = 0;
        check_count     = 0;
        load_done       = 1'b0;

        load_cases();
        load_done = 1'b1;

        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        // drive on the edge, sample one step before the next edge
        if (error_count == 0) begin
            for (int k = 0; k < num_cases; k++) begin
                @(posedge CLK);
                drive_case(k);
                #(CLK_PERIOD - 1);
                check_case(k);
            end
        end

        $display("iq_tb: %0d cases, %0d checks, %0d errors",
                 num_cases, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // one clock per case plus reset, with some slack
    initial begin
        wait (load_done);
        #((num_cases + RESET_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD);
        $display("watchdog expired before the case replay finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/iq_cases.txt ====
# stimulus: enq pipe(0 alu 1 mdu) op a_pr a_rdy a_zero b_pr b_rdy b_zero dest rob wb_v wb_bank wb_upper alu_rdy mdu_rdy
# expected: enq_ready alu_v mdu_v dest rob a_is_reg a_fwd b_is_reg b_fwd prf_a_v prf_b_v (all hex)
# reset state
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 0 0 00 00 0 0 0 0 0 0
# plain issue one cycle after enqueue
1 0 3 11 1 0 22 1 0 30 05 0 0 00 1 1   1 0 0 00 00 0 0 0 0 0 0
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 1 0 30 05 1 0 1 0 1 1
# oldest first across collapses, zero operand on the last op
1 0 1 04 1 0 08 1 0 31 06 0 0 00 0 1   1 0 0 00 00 0 0 0 0 0 0
1 0 2 0c 1 0 10 1 0 32 07 0 0 00 0 1   1 0 0 00 00 0 0 0 0 0 0
1 0 4 14 1 0 18 1 0 33 08 0 0 00 0 1   1 0 0 00 00 0 0 0 0 0 0
1 0 5 1c 1 0 00 0 1 34 09 0 0 00 1 1   1 1 0 31 06 1 0 1 0 1 1
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 1 0 32 07 1 0 1 0 1 1
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 1 0 33 08 1 0 1 0 1 1
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 1 0 34 09 1 0 0 0 1 0
# wakeup on bank 1 issues in the same cycle
1 0 6 2d 0 0 09 1 0 35 0a 0 0 00 1 1   1 0 0 00 00 0 0 0 0 0 0
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 0 0 00 00 0 0 0 0 0 0
0 0 0 00 0 0 00 0 0 00 00 1 1 0b 1 1   1 1 0 35 0a 0 1 1 0 0 1
# wakeup on bank 3 while the mdu stalls, latched for later
1 1 7 0e 1 0 3b 0 0 36 0b 0 0 00 1 1   1 0 0 00 00 0 0 0 0 0 0
0 0 0 00 0 0 00 0 0 00 00 1 3 0e 1 0   1 0 0 00 00 0 0 0 0 0 0
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 0 1 36 0b 1 0 1 0 1 1
# younger alu op passes a stalled mdu op
1 1 8 05 1 0 06 1 0 37 0c 0 0 00 1 0   1 0 0 00 00 0 0 0 0 0 0
1 0 9 07 1 0 0a 1 0 38 0d 0 0 00 1 0   1 0 0 00 00 0 0 0 0 0 0
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 0   1 1 0 38 0d 1 0 1 0 1 1
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 0 1 37 0c 1 0 1 0 1 1
# fill the queue while both pipes stall, fifth enqueue dropped
1 0 a 0d 1 0 0f 1 0 39 10 0 0 00 0 0   1 0 0 00 00 0 0 0 0 0 0
1 1 b 12 1 0 13 1 0 3a 11 0 0 00 0 0   1 0 0 00 00 0 0 0 0 0 0
1 0 c 15 1 0 16 1 0 3b 12 0 0 00 0 0   1 0 0 00 00 0 0 0 0 0 0
1 0 d 17 1 0 19 1 0 3c 13 0 0 00 0 0   1 0 0 00 00 0 0 0 0 0 0
1 0 e 1a 1 0 1b 1 0 3d 14 0 0 00 0 0   0 0 0 00 00 0 0 0 0 0 0
0 0 0 00 0 0 00 0 0 00 00 0 0 00 0 0   0 0 0 00 00 0 0 0 0 0 0
# drain, the mdu op last
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 0   0 1 0 39 10 1 0 1 0 1 1
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 0   1 1 0 3b 12 1 0 1 0 1 1
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 0   1 1 0 3c 13 1 0 1 0 1 1
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 0   1 0 0 00 00 0 0 0 0 0 0
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 0 1 3a 11 1 0 1 0 1 1
0 0 0 00 0 0 00 0 0 00 00 0 0 00 1 1   1 0 0 00 00 0 0 0 0 0 0

// ==== sim.f ====
verilog/iq_pkg.sv
verilog/oldest_pick.sv
verilog/operand_wakeup.sv
verilog/collapse_queue.sv
verilog/issue_select.sv
verilog/alu_mdu_iq.sv
dv/iq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the issue queue testbench with Verilator, run it and
# report pass or fail through the exit status

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module iq_tb -f sim.f -Mdir obj_dir; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Viq_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi

echo "pass message not found in the simulation output"
exit 1
